/* src/mmio_params.svh */
/*
  Widths, register addresses and parity sense of the MMIO register slave.
  Included by every design file that needs one of these values.
*/
`ifndef MMIO_PARAMS_SVH
`define MMIO_PARAMS_SVH

// Request address, bit 0 is the most significant, bit 23 picks the word half
`define MMIO_ADDR_W 24
`define MMIO_DATA_W 64

// Bit 0 data parity error, bit 1 address parity error
`define MMIO_ERR_W 2

// Register space, full word addresses
`define MMIO_ALGO_REQUEST 24'h00_0040
`define MMIO_ALGO_STATUS  24'h00_0042
`define MMIO_ERROR_REG    24'h00_0044

// 1 selects odd parity
`define MMIO_ODD_PARITY 1'b1

// Descriptor size in doublewords
`define MMIO_DESC_WORDS 8

`endif

/* src/mmio_pkg.sv */
/*
  Shared types and functions of the MMIO slave: the descriptor word view,
  the descriptor table and the parity generator.
*/
`default_nettype none

`include "mmio_params.svh"

package mmio_pkg;

  // One descriptor word, seen whole or as two single words
  typedef union packed {
    logic [0:`MMIO_DATA_W-1] dword;
    struct packed {
      logic [0:`MMIO_DATA_W/2-1] upper;
      logic [0:`MMIO_DATA_W/2-1] lower;
    } half;
  } cfg_word_t;

  // Fixed accelerator descriptor, indexed by doubleword
  function automatic cfg_word_t read_descriptor(input logic [0:`MMIO_ADDR_W-2] index);
    cfg_word_t word;
    word.dword = '0;
    if (index < `MMIO_DESC_WORDS) begin
      case (index)
        // 0 interrupts, 1 process, 1 register set, dedicated model
        23'd0: word.dword = 64'h0000_0001_0001_8010;
        23'd4: word.dword = 64'h0000_0000_0000_0100;
        // Per-process area required
        23'd5: word.dword = 64'h0100_0000_0000_0000;
        default: word.dword = '0;
      endcase
    end
    return word;
  endfunction

  // Parity bit that makes the total count of ones odd
  function automatic logic odd_parity_of(input logic [`MMIO_DATA_W-1:0] value);
    return (^value) ^ `MMIO_ODD_PARITY;
  endfunction

endpackage

`default_nettype wire

/* src/mmio_if.sv */
/*
  Decoded host request, passed from the capture stage to the register file.
  Strobes are single cycle and qualify the payload in the same cycle.
*/
`timescale 1ns/1ps
`default_nettype none

`include "mmio_params.svh"

interface mmio_if;

  logic                    cfg_read;
  logic                    cfg_write;
  logic                    reg_read;
  logic                    reg_write;
  logic                    doubleword;
  logic [0:`MMIO_ADDR_W-1] address;
  logic [0:`MMIO_DATA_W-1] data;

  modport capture (
    output cfg_read, cfg_write, reg_read, reg_write, doubleword, address, data
  );

  modport regfile (
    input cfg_read, cfg_write, reg_read, reg_write, doubleword, address, data
  );

endinterface

`default_nettype wire

/* src/mmio_capture.sv */
/*
  Host side of the MMIO slave. Registers each request, decodes it into one of
  four strobes two cycles later and checks address and write data parity.
*/
`timescale 1ns/1ps
`default_nettype none

`include "mmio_params.svh"

module mmio_capture (
  input  wire logic                    clock,
  input  wire logic                    rstn,
  input  wire logic                    req_valid,
  input  wire logic                    req_cfg,
  input  wire logic                    req_read,
  input  wire logic                    req_doubleword,
  input  wire logic [0:`MMIO_ADDR_W-1] req_address,
  input  wire logic                    req_address_parity,
  input  wire logic [0:`MMIO_DATA_W-1] req_data,
  input  wire logic                    req_data_parity,
  output logic      [0:`MMIO_ERR_W-1]  mmio_errors,
  mmio_if.capture                      req
);

  logic                    raw_valid;
  logic                    raw_cfg;
  logic                    raw_read;
  logic                    raw_doubleword;
  logic [0:`MMIO_ADDR_W-1] raw_address;
  logic                    raw_address_parity;
  logic [0:`MMIO_DATA_W-1] raw_data;
  logic                    raw_data_parity;

  logic [0:3]              s1_strobe;
  logic                    s1_doubleword;
  logic [0:`MMIO_ADDR_W-1] s1_address;
  logic [0:`MMIO_DATA_W-1] s1_data;

  logic [0:`MMIO_ERR_W-1]  err_s1;
  logic [0:`MMIO_ERR_W-1]  err_s2;
  logic [0:`MMIO_ERR_W-1]  err_s3;

  logic                    addr_par_calc;
  logic                    data_par_calc;

  assign addr_par_calc = mmio_pkg::odd_parity_of(
    {{(`MMIO_DATA_W-`MMIO_ADDR_W){1'b0}}, raw_address});
  assign data_par_calc = mmio_pkg::odd_parity_of(raw_data);

  //////////////////////////////
  // Control pipeline
  //////////////////////////////
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      raw_valid     <= 1'b0;
      s1_strobe     <= '0;
      req.cfg_read  <= 1'b0;
      req.cfg_write <= 1'b0;
      req.reg_read  <= 1'b0;
      req.reg_write <= 1'b0;
      err_s1        <= '0;
      err_s2        <= '0;
      err_s3        <= '0;
      mmio_errors   <= '0;
    end else begin
      raw_valid    <= req_valid;
      // Order: cfg read, cfg write, reg read, reg write
      s1_strobe[0] <= raw_valid &  raw_cfg &  raw_read;
      s1_strobe[1] <= raw_valid &  raw_cfg & ~raw_read;
      s1_strobe[2] <= raw_valid & ~raw_cfg &  raw_read;
      s1_strobe[3] <= raw_valid & ~raw_cfg & ~raw_read;
      req.cfg_read  <= s1_strobe[0];
      req.cfg_write <= s1_strobe[1];
      req.reg_read  <= s1_strobe[2];
      req.reg_write <= s1_strobe[3];
      // Write data only carries meaningful parity on writes
      err_s1[0]   <= raw_valid & ~raw_read & (data_par_calc ^ raw_data_parity);
      err_s1[1]   <= raw_valid & (addr_par_calc ^ raw_address_parity);
      err_s2      <= err_s1;
      err_s3      <= err_s2;
      mmio_errors <= err_s3;
    end
  end

  //////////////////////////////
  // Payload pipeline
  //////////////////////////////
  always_ff @(posedge clock) begin
    raw_cfg            <= req_cfg;
    raw_read           <= req_read;
    raw_doubleword     <= req_doubleword;
    raw_address        <= req_address;
    raw_address_parity <= req_address_parity;
    raw_data           <= req_data;
    raw_data_parity    <= req_data_parity;
    s1_doubleword      <= raw_doubleword;
    s1_address         <= raw_address;
    s1_data            <= raw_data;
    req.doubleword     <= s1_doubleword;
    req.address        <= s1_address;
    req.data           <= s1_data;
  end

endmodule

`default_nettype wire

/* src/mmio_regfile.sv */
/*
  Register processing of the MMIO slave. Serves descriptor and register reads,
  issues the algorithm request pulse and times the engine handshakes.
*/
`timescale 1ns/1ps
`default_nettype none

`include "mmio_params.svh"

module mmio_regfile (
  input  wire logic                    clock,
  input  wire logic                    rstn,
  mmio_if.regfile                      req,
  input  wire logic [0:`MMIO_DATA_W-1] algorithm_status,
  input  wire logic [0:`MMIO_DATA_W-1] report_errors,
  output logic      [0:`MMIO_DATA_W-1] algorithm_requests,
  output logic                         report_errors_ack,
  output logic                         reset_mmio,
  output logic                         ack_pulse,
  output logic      [0:`MMIO_DATA_W-1] read_data
);

  mmio_pkg::cfg_word_t       desc_word;
  logic [0:`MMIO_DATA_W/2-1] desc_half;

  logic addr_is_request;
  logic addr_is_status;
  logic addr_is_error;

  // Read strobes one stage before the handshake outputs
  logic status_rd;
  logic error_rd;

  assign desc_word = mmio_pkg::read_descriptor(req.address[0:`MMIO_ADDR_W-2]);
  // Address bit 23 set selects the less significant single word
  assign desc_half = req.address[`MMIO_ADDR_W-1] ? desc_word.half.lower
                                                 : desc_word.half.upper;

  assign addr_is_request = (req.address == `MMIO_ALGO_REQUEST);
  assign addr_is_status  = (req.address == `MMIO_ALGO_STATUS);
  assign addr_is_error   = (req.address == `MMIO_ERROR_REG);

  //////////////////////////////
  // Reads, writes and acknowledge
  //////////////////////////////
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      ack_pulse          <= 1'b0;
      algorithm_requests <= '0;
      read_data          <= '0;
      status_rd          <= 1'b0;
      error_rd           <= 1'b0;
    end else begin
      ack_pulse <= req.cfg_read | req.cfg_write | req.reg_read | req.reg_write;
      algorithm_requests <= (req.reg_write && addr_is_request) ? req.data : '0;
      status_rd <= req.reg_read && addr_is_status && (|algorithm_status);
      error_rd  <= req.reg_read && addr_is_error;
      if (req.cfg_read) begin
        read_data <= req.doubleword ? desc_word.dword : {desc_half, desc_half};
      end else if (req.reg_read && addr_is_status) begin
        read_data <= algorithm_status;
      end else if (req.reg_read && addr_is_error) begin
        read_data <= report_errors;
      end
      // Unmapped reads keep the previous word
    end
  end

  //////////////////////////////
  // Engine handshakes
  //////////////////////////////
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      report_errors_ack <= 1'b0;
      reset_mmio        <= 1'b1;
    end else begin
      report_errors_ack <= error_rd;
      // Single low cycle, a second status read right after is absorbed
      reset_mmio <= !(status_rd && reset_mmio);
    end
  end

endmodule

`default_nettype wire

/* src/mmio_response.sv */
/*
  Response side of the MMIO slave. Registers the acknowledge and the
  response word and adds odd parity on the returned data.
*/
`timescale 1ns/1ps
`default_nettype none

`include "mmio_params.svh"

module mmio_response (
  input  wire logic                    clock,
  input  wire logic                    rstn,
  input  wire logic                    ack_pulse,
  input  wire logic [0:`MMIO_DATA_W-1] read_data,
  output logic                         resp_ack,
  output logic      [0:`MMIO_DATA_W-1] resp_data,
  output logic                         resp_data_parity
);

  logic data_parity;

  assign data_parity = mmio_pkg::odd_parity_of(read_data);

  // Acknowledge, one cycle per request
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      resp_ack <= 1'b0;
    end else begin
      resp_ack <= ack_pulse;
    end
  end

  // Word follows read_data, so it holds between reads
  always_ff @(posedge clock) begin
    resp_data        <= read_data;
    resp_data_parity <= data_parity;
  end

endmodule

`default_nettype wire

/* src/mmio_top.sv */
/*
  Top level of the MMIO register slave: capture, register file and response
  stages joined by the request interface. All host and engine signals are plain.
*/
`timescale 1ns/1ps
`default_nettype none

`include "mmio_params.svh"

module mmio_top (
  input  wire logic                    clock,
  input  wire logic                    rstn,
  // Host request
  input  wire logic                    req_valid,
  input  wire logic                    req_cfg,
  input  wire logic                    req_read,
  input  wire logic                    req_doubleword,
  input  wire logic [0:`MMIO_ADDR_W-1] req_address,
  input  wire logic                    req_address_parity,
  input  wire logic [0:`MMIO_DATA_W-1] req_data,
  input  wire logic                    req_data_parity,
  // Host response
  output wire logic                    resp_ack,
  output wire logic [0:`MMIO_DATA_W-1] resp_data,
  output wire logic                    resp_data_parity,
  // Engine side
  input  wire logic [0:`MMIO_DATA_W-1] algorithm_status,
  input  wire logic [0:`MMIO_DATA_W-1] report_errors,
  output wire logic [0:`MMIO_DATA_W-1] algorithm_requests,
  output wire logic                    report_errors_ack,
  output wire logic                    reset_mmio,
  output wire logic [0:`MMIO_ERR_W-1]  mmio_errors
);

  wire logic                    ack_pulse;
  wire logic [0:`MMIO_DATA_W-1] read_data;

  mmio_if req_if ();

  mmio_capture mmio_capture_inst (
    .clock              (clock),
    .rstn               (rstn),
    .req_valid          (req_valid),
    .req_cfg            (req_cfg),
    .req_read           (req_read),
    .req_doubleword     (req_doubleword),
    .req_address        (req_address),
    .req_address_parity (req_address_parity),
    .req_data           (req_data),
    .req_data_parity    (req_data_parity),
    .mmio_errors        (mmio_errors),
    .req                (req_if.capture)
  );

  mmio_regfile mmio_regfile_inst (
    .clock              (clock),
    .rstn               (rstn),
    .req                (req_if.regfile),
    .algorithm_status   (algorithm_status),
    .report_errors      (report_errors),
    .algorithm_requests (algorithm_requests),
    .report_errors_ack  (report_errors_ack),
    .reset_mmio         (reset_mmio),
    .ack_pulse          (ack_pulse),
    .read_data          (read_data)
  );

  mmio_response mmio_response_inst (
    .clock            (clock),
    .rstn             (rstn),
    .ack_pulse        (ack_pulse),
    .read_data        (read_data),
    .resp_ack         (resp_ack),
    .resp_data        (resp_data),
    .resp_data_parity (resp_data_parity)
  );

endmodule

`default_nettype wire

/* sim/mmio_properties.sv */
/*
  Concurrent checks on the MMIO slave outputs.
  Bound to mmio_top from the testbench.
*/
`timescale 1ns/1ps
`default_nettype none

`include "mmio_params.svh"

module mmio_properties (
  input wire logic                    clock,
  input wire logic                    rstn,
  input wire logic                    req_valid,
  input wire logic                    req_cfg,
  input wire logic                    req_read,
  input wire logic [0:`MMIO_ADDR_W-1] req_address,
  input wire logic                    resp_ack,
  input wire logic [0:`MMIO_DATA_W-1] algorithm_requests,
  input wire logic                    reset_mmio
);

  int failure_count = 0;

  // Sampled ack trails the sampled request by five edges
  ack_back_to_back: assert property (
    @(posedge clock) disable iff (!rstn)
    (resp_ack && $past(resp_ack)) |-> ($past(req_valid, 5) && $past(req_valid, 6))
  ) else begin
    failure_count++;
    $error("resp_ack high for two cycles without two back to back requests");
  end

  // Pulse only from a write to the request register
  request_pulse_source: assert property (
    @(posedge clock) disable iff (!rstn)
    (algorithm_requests != '0) |->
      $past(req_valid && !req_cfg && !req_read && (req_address == `MMIO_ALGO_REQUEST), 4)
  ) else begin
    failure_count++;
    $error("algorithm_requests nonzero without a matching register write");
  end

  reset_single_low: assert property (
    @(posedge clock) disable iff (!rstn)
    !reset_mmio |=> reset_mmio
  ) else begin
    failure_count++;
    $error("reset_mmio low for two cycles in a row");
  end

endmodule

`default_nettype wire

/* sim/mmio_tb.sv */
/*
  Testbench of the MMIO register slave. Drives directed and random host
  requests, predicts every response with a reference model and compares.
*/
`timescale 1ns/1ps
`default_nettype none

`include "mmio_params.svh"

module mmio_tb;

  localparam int clock_period  = 40;
  localparam int reset_cycles  = 8;
  localparam int num_batches   = 4;
  localparam int batch_len     = 16;
  localparam int num_requests  = 10 + 6 + 5 + 5 + 5 + num_batches * batch_len;
  localparam int watchdog_cycles = num_requests * 6 + reset_cycles + 100;

  typedef struct packed {
    logic                    cfg;
    logic                    read;
    logic                    dword;
    logic [0:`MMIO_ADDR_W-1] address;
    logic [0:`MMIO_DATA_W-1] data;
    logic                    bad_addr;
    logic                    bad_data;
    logic [31:0]             taken;
    logic [0:`MMIO_DATA_W-1] exp_data;
    logic                    exp_parity;
    logic [0:`MMIO_ERR_W-1]  exp_errors;
    logic                    exp_err_ack;
    logic                    exp_status_drop;
    logic [0:`MMIO_DATA_W-1] exp_alg;
  } request_t;

  logic                    clock;
  logic                    rstn;
  logic                    req_valid;
  logic                    req_cfg;
  logic                    req_read;
  logic                    req_doubleword;
  logic [0:`MMIO_ADDR_W-1] req_address;
  logic                    req_address_parity;
  logic [0:`MMIO_DATA_W-1] req_data;
  logic                    req_data_parity;
  logic                    resp_ack;
  logic [0:`MMIO_DATA_W-1] resp_data;
  logic                    resp_data_parity;
  logic [0:`MMIO_DATA_W-1] algorithm_status;
  logic [0:`MMIO_DATA_W-1] report_errors;
  logic [0:`MMIO_DATA_W-1] algorithm_requests;
  logic                    report_errors_ack;
  logic                    reset_mmio;
  logic [0:`MMIO_ERR_W-1]  mmio_errors;

  request_t                pending[$];
  logic [0:`MMIO_DATA_W-1] model_read_data = '0;
  logic                    reset_prev = 1'b1;
  logic [31:0]             rng_state = 32'd39;
  int                      cycle = 0;
  int                      check_count = 0;
  int                      error_count = 0;

  mmio_top mmio_top_inst (.*);

  bind mmio_top mmio_properties mmio_properties_inst (
    .clock              (clock),
    .rstn               (rstn),
    .req_valid          (req_valid),
    .req_cfg            (req_cfg),
    .req_read           (req_read),
    .req_address        (req_address),
    .resp_ack           (resp_ack),
    .algorithm_requests (algorithm_requests),
    .reset_mmio         (reset_mmio)
  );

  initial begin
    clock = 1'b0;
    forever #(clock_period / 2) clock = ~clock;
  end

  always @(posedge clock) cycle <= cycle + 1;

  //////////////////////////////
  // Random numbers
  //////////////////////////////
  function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic logic [0:`MMIO_DATA_W-1] random_word();
    return {next_random(), next_random()};
  endfunction

  //////////////////////////////
  // Reference model
  //////////////////////////////
  function automatic logic [0:`MMIO_DATA_W-1] descriptor_word(input logic [22:0] index);
    case (index)
      23'd0: return 64'h0000_0001_0001_8010;
      23'd4: return 64'h0000_0000_0000_0100;
      // Per-process area required
      23'd5: return 64'h0100_0000_0000_0000;
      default: return '0;
    endcase
  endfunction

  function automatic request_t expected_response(input request_t r,
                                                 input logic [0:`MMIO_DATA_W-1] status,
                                                 input logic [0:`MMIO_DATA_W-1] errors);
    request_t e;
    logic [0:`MMIO_DATA_W-1] word;
    logic [0:`MMIO_DATA_W/2-1] half;
    e = r;
    if (r.cfg && r.read) begin
      word = descriptor_word(r.address[0:`MMIO_ADDR_W-2]);
      half = r.address[`MMIO_ADDR_W-1] ? word[32:63] : word[0:31];
      model_read_data = r.dword ? word : {half, half};
    end else if (!r.cfg && r.read && r.address == `MMIO_ALGO_STATUS) begin
      model_read_data = status;
      e.exp_status_drop = |status;
    end else if (!r.cfg && r.read && r.address == `MMIO_ERROR_REG) begin
      model_read_data = errors;
      e.exp_err_ack = 1'b1;
    end else if (!r.cfg && !r.read && r.address == `MMIO_ALGO_REQUEST) begin
      e.exp_alg = r.data;
    end
    e.exp_data      = model_read_data;
    e.exp_parity    = ~(^model_read_data);
    e.exp_errors[0] = r.bad_data && !r.read;
    e.exp_errors[1] = r.bad_addr;
    return e;
  endfunction

  //////////////////////////////
  // Stimulus helpers
  //////////////////////////////
  task automatic issue_request(input logic cfg, input logic read, input logic dword,
                               input logic [0:`MMIO_ADDR_W-1] address,
                               input logic [0:`MMIO_DATA_W-1] data,
                               input logic bad_addr, input logic bad_data);
    request_t r;
    @(negedge clock);
    req_valid          = 1'b1;
    req_cfg            = cfg;
    req_read           = read;
    req_doubleword     = dword;
    req_address        = address;
    req_address_parity = ~(^address) ^ bad_addr;
    req_data           = data;
    req_data_parity    = ~(^data) ^ bad_data;
    r          = '0;
    r.cfg      = cfg;
    r.read     = read;
    r.dword    = dword;
    r.address  = address;
    r.data     = data;
    r.bad_addr = bad_addr;
    r.bad_data = bad_data;
    r.taken    = cycle + 1;
    pending.push_back(expected_response(r, algorithm_status, report_errors));
  endtask

  task automatic drain();
    @(negedge clock);
    req_valid = 1'b0;
    while (pending.size() != 0) @(negedge clock);
  endtask

  task automatic random_request();
    logic [31:0] r;
    logic [0:`MMIO_ADDR_W-1] addr;
    r = next_random();
    if (!r[1]) begin
      addr = {19'd0, r[14:11], r[15]};
    end else begin
      case (r[17:16])
        2'd0: addr = `MMIO_ALGO_REQUEST;
        2'd1: addr = `MMIO_ALGO_STATUS;
        2'd2: addr = `MMIO_ERROR_REG;
        default: addr = r[31:8];
      endcase
    end
    issue_request(~r[1], r[0], r[2], addr, random_word(), r[7:5] == 3'd0, r[10:8] == 3'd0);
  endtask

  //////////////////////////////
  // Comparison
  //////////////////////////////
  task automatic compare_signal(input string name, input logic [0:`MMIO_DATA_W-1] got,
                                input logic [0:`MMIO_DATA_W-1] exp);
    check_count++;
    assert (got === exp) else begin
      error_count++;
      $display("Mismatch %s: got %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  always @(negedge clock) begin : compare_outputs
    request_t due;
    logic [0:`MMIO_DATA_W-1] alg_exp;
    logic reset_exp;
    logic have_due;
    if (rstn) begin
      alg_exp = '0;
      foreach (pending[i]) begin
        if (pending[i].taken + 3 == cycle) alg_exp = pending[i].exp_alg;
      end
      have_due = (pending.size() != 0) && (pending[0].taken + 4 == cycle);
      due = '0;
      if (have_due) due = pending.pop_front();
      // A drop right after another drop is absorbed
      reset_exp  = !(due.exp_status_drop && reset_prev);
      reset_prev = reset_exp;
      compare_signal("resp_ack", resp_ack, have_due);
      compare_signal("algorithm_requests", algorithm_requests, alg_exp);
      compare_signal("mmio_errors", mmio_errors, due.exp_errors);
      compare_signal("report_errors_ack", report_errors_ack, due.exp_err_ack);
      compare_signal("reset_mmio", reset_mmio, reset_exp);
      if (have_due) begin
        compare_signal("resp_data", resp_data, due.exp_data);
        compare_signal("resp_data_parity", resp_data_parity, due.exp_parity);
      end
    end
  end

  initial begin
    #(watchdog_cycles * clock_period);
    $display("Timeout: the requests did not complete in the expected time");
    $display("test failed");
    $finish;
  end

  //////////////////////////////
  // Test sequence
  //////////////////////////////
  initial begin
    int i;
    int idx;
    int property_errors;
    rstn = 1'b0;
    req_valid = 1'b0;
    req_cfg = 1'b0;
    req_read = 1'b0;
    req_doubleword = 1'b0;
    req_address = '0;
    req_address_parity = 1'b0;
    req_data = '0;
    req_data_parity = 1'b0;
    algorithm_status = '0;
    report_errors = '0;
    repeat (reset_cycles) @(posedge clock);
    @(negedge clock);
    rstn = 1'b1;

    // Doubleword descriptor reads, two indexes past the table
    for (i = 0; i < 10; i++) begin
      issue_request(1'b1, 1'b1, 1'b1, {i[22:0], 1'b0}, random_word(), 1'b0,
                    next_random() % 2 == 1);
    end
    drain();

    // Single word reads, both halves
    for (i = 0; i < 6; i++) begin
      idx = (i < 2) ? 0 : (i < 4) ? 4 : 5;
      issue_request(1'b1, 1'b1, 1'b0, {idx[22:0], i[0]}, random_word(), 1'b0, 1'b0);
    end
    drain();

    // Writes, only the request address pulses
    issue_request(1'b0, 1'b0, 1'b1, `MMIO_ALGO_REQUEST, random_word(), 1'b0, 1'b0);
    issue_request(1'b0, 1'b0, 1'b1, `MMIO_ALGO_REQUEST, random_word(), 1'b0, 1'b0);
    issue_request(1'b0, 1'b0, 1'b1, `MMIO_ALGO_STATUS, random_word(), 1'b0, 1'b0);
    issue_request(1'b0, 1'b0, 1'b1, `MMIO_ERROR_REG, random_word(), 1'b0, 1'b0);
    issue_request(1'b1, 1'b0, 1'b1, 24'h00_0000, random_word(), 1'b0, 1'b0);
    drain();

    // Status and error reads, then an unmapped read
    algorithm_status = random_word() | 64'h1;
    report_errors = random_word();
    issue_request(1'b0, 1'b1, 1'b1, `MMIO_ALGO_STATUS, '0, 1'b0, 1'b0);
    issue_request(1'b0, 1'b1, 1'b1, `MMIO_ALGO_STATUS, '0, 1'b0, 1'b0);
    issue_request(1'b0, 1'b1, 1'b1, `MMIO_ERROR_REG, '0, 1'b0, 1'b0);
    issue_request(1'b0, 1'b1, 1'b1, 24'h00_0100, '0, 1'b0, 1'b0);
    drain();
    algorithm_status = '0;
    issue_request(1'b0, 1'b1, 1'b1, `MMIO_ALGO_STATUS, '0, 1'b0, 1'b0);
    drain();

    // Parity faults, data parity on a read is ignored
    issue_request(1'b1, 1'b1, 1'b1, 24'h00_0000, random_word(), 1'b1, 1'b0);
    issue_request(1'b0, 1'b0, 1'b1, `MMIO_ERROR_REG, random_word(), 1'b0, 1'b1);
    issue_request(1'b1, 1'b1, 1'b1, 24'h00_0008, random_word(), 1'b0, 1'b1);
    issue_request(1'b1, 1'b0, 1'b1, 24'h00_0002, random_word(), 1'b1, 1'b1);
    issue_request(1'b1, 1'b1, 1'b1, 24'h00_000a, random_word(), 1'b0, 1'b0);
    drain();

    // Random back to back traffic, status held per batch
    for (i = 0; i < num_batches; i++) begin
      algorithm_status = (i == 1) ? '0 : random_word();
      report_errors = random_word();
      repeat (batch_len) random_request();
      drain();
    end

    repeat (4) @(negedge clock);
    property_errors = mmio_top_inst.mmio_properties_inst.failure_count;
    $display("Checks run: %0d, errors: %0d, assertion failures: %0d",
             check_count, error_count, property_errors);
    if (error_count == 0 && property_errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
+incdir+src
src/mmio_pkg.sv
src/mmio_if.sv
src/mmio_capture.sv
src/mmio_regfile.sv
src/mmio_response.sv
src/mmio_top.sv
sim/mmio_properties.sv
sim/mmio_tb.sv

/* Bender.yml */
package:
  name: mmio_slave

sources:
  - include_dirs:
      - src
    files:
      - src/mmio_pkg.sv
      - src/mmio_if.sv
      - src/mmio_capture.sv
      - src/mmio_regfile.sv
      - src/mmio_response.sv
      - src/mmio_top.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - sim/mmio_properties.sv
      - sim/mmio_tb.sv
